// File: rtl/ex_consts.svh
// widths, opcodes and funct3/funct7 encodings for the execute stage
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define XLEN 32

// major opcodes
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

// alu funct3, shared by imm and reg forms
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101

`define F3_SB 3'b000
`define F3_SH 3'b001
`define F3_SW 3'b010

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_MUL    3'b000
`define F3_MULH   3'b001
`define F3_MULHSU 3'b010
`define F3_MULHU  3'b011

`define F7_BASE   7'b0000000
`define F7_ALT    7'b0100000
`define F7_MULDIV 7'b0000001

`endif

// File: rtl/ex_pkg.sv
// shared types of the execute stage
// operation class, decoded fields, compare vector and output buses
`include "ex_consts.svh"

package ex_pkg;

    // nine classes, so four bits
    typedef enum logic [3:0] {
        op_none    = 4'd0,
        op_alu_imm = 4'd1,
        op_alu_reg = 4'd2,
        op_mul     = 4'd3,
        op_load    = 4'd4,
        op_store   = 4'd5,
        op_branch  = 4'd6,
        op_jump    = 4'd7,
        op_upper   = 4'd8
    } op_class_e;

    typedef struct packed {
        op_class_e  op_class;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic       alt;      // inst bit 30
    } inst_fields_t;

    // eq ends up in bit 0
    typedef struct packed {
        logic ge;   // signed
        logic geu;  // unsigned
        logic eq;
    } cmp_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic             we;
        logic             req;
    } mem_bus_t;

    typedef struct packed {
        logic [`XLEN-1:0] data;
        logic             we;
        logic [4:0]       waddr;
    } wb_t;

    typedef struct packed {
        logic             flag;
        logic [`XLEN-1:0] addr;
    } jump_t;

endpackage

// File: rtl/ex_decode.sv
// instruction field split and operation classification
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_decode (
    input  logic [`XLEN-1:0]    inst_i,
    output ex_pkg::inst_fields_t fields_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        fields_o.funct3 = funct3;
        fields_o.rd     = inst_i[11:7];
        fields_o.shamt  = inst_i[24:20];
        fields_o.alt    = inst_i[30];
    end

    always_comb begin
        fields_o.op_class = ex_pkg::op_none;
        case (opcode)
            `OP_IMM: fields_o.op_class = ex_pkg::op_alu_imm;
            `OP_REG: begin
                if (funct7 == `F7_BASE || funct7 == `F7_ALT) begin
                    fields_o.op_class = ex_pkg::op_alu_reg;
                end else if (funct7 == `F7_MULDIV && !funct3[2]) begin
                    fields_o.op_class = ex_pkg::op_mul;  // div/rem stay none
                end
            end
            `OP_LOAD:            fields_o.op_class = ex_pkg::op_load;
            `OP_STORE:           fields_o.op_class = ex_pkg::op_store;
            `OP_BRANCH:          fields_o.op_class = ex_pkg::op_branch;
            `OP_JAL, `OP_JALR:   fields_o.op_class = ex_pkg::op_jump;
            `OP_LUI, `OP_AUIPC:  fields_o.op_class = ex_pkg::op_upper;
            default:             fields_o.op_class = ex_pkg::op_none;
        endcase
    end

endmodule

// File: rtl/ex_alu.sv
// integer alu, shifter, signed-magnitude multiplier and address adder
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::inst_fields_t fields_i,
    input  logic [`XLEN-1:0]     op1_i,
    input  logic [`XLEN-1:0]     op2_i,
    input  ex_pkg::cmp_t         cmp_i,
    input  logic [`XLEN-1:0]     inst_addr_next_i,
    output logic [`XLEN-1:0]     sum_o,
    output logic [`XLEN-1:0]     result_o
);

    logic                 reg_form;
    logic [4:0]           shamt;
    logic [`XLEN-1:0]     diff;
    logic [`XLEN-1:0]     shl;
    logic [`XLEN-1:0]     shr;
    logic [`XLEN-1:0]     shr_arith;
    logic                 mul_neg1;
    logic                 mul_neg2;
    logic [`XLEN-1:0]     mul_op1;
    logic [`XLEN-1:0]     mul_op2;
    logic [2*`XLEN-1:0]   product;
    logic [2*`XLEN-1:0]   product_neg;
    logic [`XLEN-1:0]     int_result;
    logic [`XLEN-1:0]     mul_result;

    // one adder for add, address, branch and jump target
    assign sum_o = op1_i + op2_i;
    assign diff  = op1_i - op2_i;

    assign reg_form = (fields_i.op_class == ex_pkg::op_alu_reg);
    assign shamt    = reg_form ? op2_i[4:0] : fields_i.shamt;

    always_comb begin
        shl       = op1_i << shamt;
        shr       = op1_i >> shamt;
        shr_arith = $unsigned($signed(op1_i) >>> shamt);
    end

    // magnitudes go into an unsigned multiply, sign fixed afterwards
    always_comb begin
        mul_neg1 = 1'b0;
        mul_neg2 = 1'b0;
        case (fields_i.funct3)
            `F3_MULH: begin
                mul_neg1 = op1_i[`XLEN-1];
                mul_neg2 = op2_i[`XLEN-1];
            end
            `F3_MULHSU: mul_neg1 = op1_i[`XLEN-1];
            default: begin
                mul_neg1 = 1'b0;
                mul_neg2 = 1'b0;
            end
        endcase
        mul_op1     = mul_neg1 ? (~op1_i + 1'b1) : op1_i;
        mul_op2     = mul_neg2 ? (~op2_i + 1'b1) : op2_i;
        product     = {{`XLEN{1'b0}}, mul_op1} * {{`XLEN{1'b0}}, mul_op2};
        product_neg = ~product + 1'b1;
    end

    always_comb begin
        case (fields_i.funct3)
            `F3_MUL:   mul_result = product[`XLEN-1:0];
            `F3_MULHU: mul_result = product[2*`XLEN-1:`XLEN];
            default: begin
                // mulh and mulhsu
                mul_result = (mul_neg1 ^ mul_neg2) ? product_neg[2*`XLEN-1:`XLEN]
                                                   : product[2*`XLEN-1:`XLEN];
            end
        endcase
    end

    always_comb begin
        case (fields_i.funct3)
            `F3_ADD:  int_result = (reg_form && fields_i.alt) ? diff : sum_o;
            `F3_SLL:  int_result = shl;
            `F3_SLT:  int_result = {{(`XLEN-1){1'b0}}, ~cmp_i.ge};
            `F3_SLTU: int_result = {{(`XLEN-1){1'b0}}, ~cmp_i.geu};
            `F3_XOR:  int_result = op1_i ^ op2_i;
            `F3_SR:   int_result = fields_i.alt ? shr_arith : shr;
            `F3_OR:   int_result = op1_i | op2_i;
            default:  int_result = op1_i & op2_i;  // and
        endcase
    end

    always_comb begin
        case (fields_i.op_class)
            ex_pkg::op_alu_imm, ex_pkg::op_alu_reg: result_o = int_result;
            ex_pkg::op_mul:   result_o = mul_result;
            ex_pkg::op_jump:  result_o = inst_addr_next_i;  // link value
            ex_pkg::op_upper: result_o = sum_o;             // lui/auipc
            default:          result_o = '0;
        endcase
    end

endmodule

// File: rtl/ex_lsu.sv
// memory request, store merge into the read word, load lane extraction
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_lsu (
    input  ex_pkg::inst_fields_t fields_i,
    input  logic [`XLEN-1:0]     addr_i,
    input  logic [`XLEN-1:0]     store_data_i,
    input  logic [`XLEN-1:0]     mem_rdata_i,
    output ex_pkg::mem_bus_t     bus_o,
    output logic [`XLEN-1:0]     load_data_o
);

    logic       is_load;
    logic       is_store;
    logic [1:0] lane;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    assign is_load  = (fields_i.op_class == ex_pkg::op_load);
    assign is_store = (fields_i.op_class == ex_pkg::op_store);
    assign lane     = addr_i[1:0];

    always_comb begin
        bus_o.req   = is_load | is_store;
        bus_o.we    = is_store;
        bus_o.addr  = bus_o.req ? addr_i : '0;
        bus_o.wdata = '0;
        if (is_store) begin
            case (fields_i.funct3)
                `F3_SB: begin
                    bus_o.wdata = mem_rdata_i;
                    case (lane)
                        2'd0:    bus_o.wdata[7:0]   = store_data_i[7:0];
                        2'd1:    bus_o.wdata[15:8]  = store_data_i[7:0];
                        2'd2:    bus_o.wdata[23:16] = store_data_i[7:0];
                        default: bus_o.wdata[31:24] = store_data_i[7:0];
                    endcase
                end
                `F3_SH: begin
                    bus_o.wdata = lane[1] ? {store_data_i[15:0], mem_rdata_i[15:0]}
                                          : {mem_rdata_i[31:16], store_data_i[15:0]};
                end
                `F3_SW:  bus_o.wdata = store_data_i;
                default: bus_o.wdata = mem_rdata_i;  // unknown width leaves word intact
            endcase
        end
    end

    always_comb begin
        case (lane)
            2'd0:    byte_sel = mem_rdata_i[7:0];
            2'd1:    byte_sel = mem_rdata_i[15:8];
            2'd2:    byte_sel = mem_rdata_i[23:16];
            default: byte_sel = mem_rdata_i[31:24];
        endcase
        half_sel = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
    end

    always_comb begin
        case (fields_i.funct3)
            `F3_LB:  load_data_o = {{24{byte_sel[7]}}, byte_sel};
            `F3_LH:  load_data_o = {{16{half_sel[15]}}, half_sel};
            `F3_LW:  load_data_o = mem_rdata_i;
            `F3_LBU: load_data_o = {24'h0, byte_sel};
            `F3_LHU: load_data_o = {16'h0, half_sel};
            default: load_data_o = '0;
        endcase
    end

    // upstream must keep halfword accesses aligned
    always_comb begin
        assert final (!((is_load || is_store) && fields_i.funct3[1:0] == 2'b01 && lane[0]))
        else $error("ex_lsu: halfword access at odd lane");
    end

endmodule

// File: rtl/ex_commit.sv
// writeback select, branch decision, interrupt override, reset gating, ready
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_commit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  ex_pkg::inst_fields_t fields_i,
    input  ex_pkg::cmp_t         cmp_i,
    input  logic [`XLEN-1:0]     alu_result_i,
    input  logic [`XLEN-1:0]     load_data_i,
    input  logic [`XLEN-1:0]     target_i,
    input  ex_pkg::mem_bus_t     bus_i,
    input  logic                 reg_we_i,
    input  logic [4:0]           reg_waddr_i,
    input  logic                 int_assert_i,
    input  logic [`XLEN-1:0]     int_addr_i,
    input  logic                 mem_ready_i,
    output ex_pkg::wb_t          wb_o,
    output ex_pkg::mem_bus_t     bus_o,
    output ex_pkg::jump_t        jump_o,
    output logic                 ready_o
);

    logic taken;
    logic jump;

    always_comb begin
        case (fields_i.funct3)
            `F3_BEQ:  taken = cmp_i.eq;
            `F3_BNE:  taken = ~cmp_i.eq;
            `F3_BLT:  taken = ~cmp_i.ge;
            `F3_BGE:  taken = cmp_i.ge;
            `F3_BLTU: taken = ~cmp_i.geu;
            `F3_BGEU: taken = cmp_i.geu;
            default:  taken = 1'b0;
        endcase
    end

    assign jump = (fields_i.op_class == ex_pkg::op_jump) ||
                  (fields_i.op_class == ex_pkg::op_branch && taken);

    always_comb begin
        wb_o.data  = (fields_i.op_class == ex_pkg::op_load) ? load_data_i : alu_result_i;
        wb_o.waddr = reg_waddr_i;
        wb_o.we    = reg_we_i;
        bus_o      = bus_i;
        jump_o.flag = jump;
        jump_o.addr = jump ? target_i : '0;

        if (int_assert_i) begin
            // interrupt wins over the instruction in flight
            wb_o.we     = 1'b0;
            bus_o.req   = 1'b0;
            bus_o.we    = 1'b0;
            jump_o.flag = 1'b1;
            jump_o.addr = int_addr_i;
        end

        if (rst_i) begin
            wb_o.we     = 1'b0;
            bus_o.req   = 1'b0;
            bus_o.we    = 1'b0;
            jump_o.flag = 1'b0;
        end
    end

    // stall while the request and the memory answer disagree
    assign ready_o = rst_i | ~(bus_o.req ^ mem_ready_i);

    a_no_jump_with_mem: assert property (@(posedge clk_i) jump_o.flag |-> !bus_o.req)
    else $error("ex_commit: memory request together with a jump");

    a_write_needs_req: assert property (@(posedge clk_i) bus_o.we |-> bus_o.req)
    else $error("ex_commit: memory write without a request");

endmodule

// File: rtl/ex_top.sv
// execute stage top, decode, alu, lsu and commit
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_top (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [`XLEN-1:0] inst_i,
    input  logic [`XLEN-1:0] inst_addr_next_i,
    input  logic             reg_we_i,
    input  logic [4:0]       reg_waddr_i,
    input  logic [`XLEN-1:0] op1_i,
    input  logic [`XLEN-1:0] op2_i,
    input  ex_pkg::cmp_t     cmp_i,
    input  logic [`XLEN-1:0] store_data_i,
    input  logic             int_assert_i,
    input  logic [`XLEN-1:0] int_addr_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    input  logic             mem_ready_i,
    output ex_pkg::mem_bus_t mem_o,
    output ex_pkg::wb_t      wb_o,
    output ex_pkg::jump_t    jump_o,
    output logic             ready_o
);

    ex_pkg::inst_fields_t fields;
    ex_pkg::mem_bus_t     lsu_bus;
    logic [`XLEN-1:0]     sum;        // address and jump target
    logic [`XLEN-1:0]     alu_result;
    logic [`XLEN-1:0]     load_data;

    ex_decode ex_decode_i (
        .inst_i   (inst_i),
        .fields_o (fields)
    );

    ex_alu ex_alu_i (
        .fields_i         (fields),
        .op1_i            (op1_i),
        .op2_i            (op2_i),
        .cmp_i            (cmp_i),
        .inst_addr_next_i (inst_addr_next_i),
        .sum_o            (sum),
        .result_o         (alu_result)
    );

    ex_lsu ex_lsu_i (
        .fields_i     (fields),
        .addr_i       (sum),
        .store_data_i (store_data_i),
        .mem_rdata_i  (mem_rdata_i),
        .bus_o        (lsu_bus),
        .load_data_o  (load_data)
    );

    ex_commit ex_commit_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fields_i     (fields),
        .cmp_i        (cmp_i),
        .alu_result_i (alu_result),
        .load_data_i  (load_data),
        .target_i     (sum),
        .bus_i        (lsu_bus),
        .reg_we_i     (reg_we_i),
        .reg_waddr_i  (reg_waddr_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .mem_ready_i  (mem_ready_i),
        .wb_o         (wb_o),
        .bus_o        (mem_o),
        .jump_o       (jump_o),
        .ready_o      (ready_o)
    );

endmodule

// File: testbench/tb_ex_top.sv
// testbench for the execute stage top level
// lcg driven random instructions checked against a reference model
`timescale 1ns/1ns
`include "ex_consts.svh"

module tb_ex_top #(
    parameter logic [31:0] SEED    = 32'hcd1b_63f6,
    parameter int          N_TESTS = 2000
);

    localparam int     CLK_PERIOD  = 100;
    localparam int     RST_CYCLES  = 10;
    localparam longint WATCHDOG_NS = longint'(N_TESTS + RST_CYCLES + 2) * CLK_PERIOD * 2;

    // one stimulus kind per kept class
    localparam int K_IMM    = 0;
    localparam int K_REG    = 1;
    localparam int K_MUL    = 2;
    localparam int K_LOAD   = 3;
    localparam int K_STORE  = 4;
    localparam int K_BRANCH = 5;
    localparam int K_JUMP   = 6;
    localparam int K_UPPER  = 7;

    logic             clk_i;
    logic             rst_i;
    logic [`XLEN-1:0] inst_i;
    logic [`XLEN-1:0] inst_addr_next_i;
    logic             reg_we_i;
    logic [4:0]       reg_waddr_i;
    logic [`XLEN-1:0] op1_i;
    logic [`XLEN-1:0] op2_i;
    ex_pkg::cmp_t     cmp_i;
    logic [`XLEN-1:0] store_data_i;
    logic             int_assert_i;
    logic [`XLEN-1:0] int_addr_i;
    logic [`XLEN-1:0] mem_rdata_i;
    logic             mem_ready_i;
    ex_pkg::mem_bus_t mem_o;
    ex_pkg::wb_t      wb_o;
    ex_pkg::jump_t    jump_o;
    logic             ready_o;

    logic [31:0] lcg_state;
    int          cur_kind;   // what the model believes was issued
    logic [2:0]  cur_f3;
    logic        cur_alt;
    logic [4:0]  cur_shamt;

    ex_top ex_top_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low bits of an lcg cycle too fast
    function automatic int pick(input int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    task automatic make_stimulus();
        logic [31:0] r;
        logic [6:0]  opcode;
        logic [6:0]  f7;
        logic [31:0] s;
        logic [31:0] mask;
        r        = next_rand();
        f7       = r[31:25];
        cur_kind = pick(8);
        cur_f3   = 3'(pick(8));
        case (cur_kind)
            K_IMM: begin
                opcode = `OP_IMM;
                if (cur_f3 == `F3_SLL) f7 = `F7_BASE;
                else if (cur_f3 == `F3_SR) f7 = pick(2) ? `F7_ALT : `F7_BASE;
            end
            K_REG: begin
                opcode = `OP_REG;
                f7 = ((cur_f3 == `F3_ADD || cur_f3 == `F3_SR) && pick(2)) ? `F7_ALT : `F7_BASE;
            end
            K_MUL: begin
                opcode = `OP_REG;
                f7     = `F7_MULDIV;
                cur_f3 = 3'(pick(4));
            end
            K_LOAD: begin
                opcode = `OP_LOAD;
                case (pick(5))
                    0:       cur_f3 = `F3_LB;
                    1:       cur_f3 = `F3_LH;
                    2:       cur_f3 = `F3_LW;
                    3:       cur_f3 = `F3_LBU;
                    default: cur_f3 = `F3_LHU;
                endcase
            end
            K_STORE: begin
                opcode = `OP_STORE;
                cur_f3 = 3'(pick(3));  // sb, sh, sw
            end
            K_BRANCH: begin
                opcode = `OP_BRANCH;
                case (pick(6))
                    0:       cur_f3 = `F3_BEQ;
                    1:       cur_f3 = `F3_BNE;
                    2:       cur_f3 = `F3_BLT;
                    3:       cur_f3 = `F3_BGE;
                    4:       cur_f3 = `F3_BLTU;
                    default: cur_f3 = `F3_BGEU;
                endcase
            end
            K_JUMP: begin
                opcode = pick(2) ? `OP_JAL : `OP_JALR;
                if (opcode == `OP_JALR) cur_f3 = 3'b000;
            end
            default: opcode = pick(2) ? `OP_LUI : `OP_AUIPC;
        endcase
        cur_alt   = f7[5];
        cur_shamt = r[24:20];
        inst_i    = {f7, r[24:15], cur_f3, r[11:7], opcode};

        op1_i = next_rand();
        op2_i = pick(4) == 0 ? op1_i : next_rand();  // some equal operands for beq
        if (cur_kind == K_LOAD || cur_kind == K_STORE) begin
            // natural alignment of the effective address
            mask  = (cur_f3[1:0] == 2'b00) ? 32'd0 : (cur_f3[1:0] == 2'b01) ? 32'd1 : 32'd3;
            s     = op1_i + op2_i;
            op1_i = op1_i - (s & mask);
        end
        cmp_i.eq  = (op1_i == op2_i);
        cmp_i.geu = (op1_i >= op2_i);
        cmp_i.ge  = ($signed(op1_i) >= $signed(op2_i));

        inst_addr_next_i = next_rand();
        store_data_i     = next_rand();
        mem_rdata_i      = next_rand();
        int_addr_i       = next_rand();
        reg_we_i         = 1'(pick(2));
        reg_waddr_i      = 5'(pick(32));
        mem_ready_i      = 1'(pick(2));
        int_assert_i     = (pick(8) == 0);
    endtask

    task automatic predict(output ex_pkg::wb_t e_wb, output ex_pkg::mem_bus_t e_bus,
                           output ex_pkg::jump_t e_jump, output logic e_ready);
        logic [31:0] sum;
        logic [31:0] res;
        logic [31:0] ld;
        logic [31:0] merged;
        logic [63:0] prod;
        logic [4:0]  sh;
        logic [31:0] fill;
        logic [1:0]  lane;
        logic [7:0]  b;
        logic [15:0] h;
        logic        taken;
        sum    = op1_i + op2_i;
        res    = '0;
        sh     = (cur_kind == K_REG) ? op2_i[4:0] : cur_shamt;
        fill   = op1_i[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // sign bits for sra
        lane   = sum[1:0];
        b      = 8'(mem_rdata_i >> (8 * lane));
        h      = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
        merged = mem_rdata_i;
        taken  = 1'b0;
        case (cur_kind)
            K_IMM, K_REG: begin
                case (cur_f3)
                    `F3_ADD:  res = (cur_kind == K_REG && cur_alt) ? op1_i - op2_i : sum;
                    `F3_SLL:  res = op1_i << sh;
                    `F3_SLT:  res = {31'b0, $signed(op1_i) < $signed(op2_i)};
                    `F3_SLTU: res = {31'b0, op1_i < op2_i};
                    `F3_XOR:  res = op1_i ^ op2_i;
                    `F3_SR:   res = cur_alt ? (op1_i >> sh) | fill : op1_i >> sh;
                    `F3_OR:   res = op1_i | op2_i;
                    default:  res = op1_i & op2_i;
                endcase
            end
            K_MUL: begin
                case (cur_f3)
                    `F3_MULH:   prod = {{32{op1_i[31]}}, op1_i} * {{32{op2_i[31]}}, op2_i};
                    `F3_MULHSU: prod = {{32{op1_i[31]}}, op1_i} * {32'b0, op2_i};
                    default:    prod = {32'b0, op1_i} * {32'b0, op2_i};
                endcase
                res = (cur_f3 == `F3_MUL) ? prod[31:0] : prod[63:32];
            end
            K_JUMP:  res = inst_addr_next_i;  // link
            K_UPPER: res = sum;
            default: res = '0;
        endcase
        case (cur_f3)
            `F3_LB:  ld = {{24{b[7]}}, b};
            `F3_LH:  ld = {{16{h[15]}}, h};
            `F3_LW:  ld = mem_rdata_i;
            `F3_LBU: ld = {24'b0, b};
            default: ld = {16'b0, h};
        endcase
        case (cur_f3)
            `F3_SB:  merged[8 * lane +: 8] = store_data_i[7:0];
            `F3_SH:  merged[16 * lane[1] +: 16] = store_data_i[15:0];
            default: merged = store_data_i;
        endcase
        case (cur_f3)
            `F3_BEQ:  taken = (op1_i == op2_i);
            `F3_BNE:  taken = (op1_i != op2_i);
            `F3_BLT:  taken = ($signed(op1_i) < $signed(op2_i));
            `F3_BGE:  taken = ($signed(op1_i) >= $signed(op2_i));
            `F3_BLTU: taken = (op1_i < op2_i);
            default:  taken = (op1_i >= op2_i);
        endcase
        taken = (cur_kind == K_JUMP) || (cur_kind == K_BRANCH && taken);

        e_wb.data    = (cur_kind == K_LOAD) ? ld : res;
        e_wb.we      = reg_we_i;
        e_wb.waddr   = reg_waddr_i;
        e_bus.req    = (cur_kind == K_LOAD || cur_kind == K_STORE);
        e_bus.we     = (cur_kind == K_STORE);
        e_bus.addr   = e_bus.req ? sum : '0;
        e_bus.wdata  = e_bus.we ? merged : '0;
        e_jump.flag  = taken;
        e_jump.addr  = taken ? sum : '0;
        if (int_assert_i) begin
            e_wb.we     = 1'b0;
            e_bus.req   = 1'b0;
            e_bus.we    = 1'b0;
            e_jump.flag = 1'b1;
            e_jump.addr = int_addr_i;
        end
        if (rst_i) begin
            e_wb.we     = 1'b0;
            e_bus.req   = 1'b0;
            e_bus.we    = 1'b0;
            e_jump.flag = 1'b0;
        end
        e_ready = rst_i || (e_bus.req == mem_ready_i);
    endtask

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "mismatch on instruction %h", inst_i);
    endtask

    task automatic check_wb(input ex_pkg::wb_t got, input ex_pkg::wb_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t wb_o got %h expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bus(input ex_pkg::mem_bus_t got, input ex_pkg::mem_bus_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t mem_o got %h expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_jump(input ex_pkg::jump_t got, input ex_pkg::jump_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t jump_o got %h expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t ready_o got %b expected %b", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_outputs();
        ex_pkg::wb_t      e_wb;
        ex_pkg::mem_bus_t e_bus;
        ex_pkg::jump_t    e_jump;
        logic             e_ready;
        predict(e_wb, e_bus, e_jump, e_ready);
        check_wb(wb_o, e_wb);
        check_bus(mem_o, e_bus);
        check_jump(jump_o, e_jump);
        check_ready(ready_o, e_ready);
    endtask

    initial begin
        lcg_state        = SEED;
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        inst_i           = '0;
        inst_addr_next_i = '0;
        reg_we_i         = 1'b0;
        reg_waddr_i      = '0;
        op1_i            = '0;
        op2_i            = '0;
        cmp_i            = '0;
        store_data_i     = '0;
        int_assert_i     = 1'b0;
        int_addr_i       = '0;
        mem_rdata_i      = '0;
        mem_ready_i      = 1'b0;
        repeat (RST_CYCLES) begin
            @(negedge clk_i);
            make_stimulus();
            @(posedge clk_i);
            check_outputs();
        end
        for (int i = 0; i < N_TESTS; i++) begin
            @(negedge clk_i);
            rst_i = 1'b0;
            make_stimulus();
            @(posedge clk_i);  // outputs settled since the falling edge
            check_outputs();
        end
        $display("%0d random instructions checked after reset", N_TESTS);
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test loop did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: all.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_lsu.sv
rtl/ex_commit.sv
rtl/ex_top.sv
testbench/tb_ex_top.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_top
OBJ_DIR   ?= obj_dir
SEED      ?= cd1b63f6
N_TESTS   ?= 2000
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-GSEED="32'h$(SEED)" -GN_TESTS=$(N_TESTS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
